/* verilog/core_pkg.sv */
`default_nettype none

package core_pkg;

    // Issue width of the back end
    parameter int NUM_LANES = 2;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [2:0]  alu_op_t;

    localparam alu_op_t ALU_ADD = 3'd0;
    localparam alu_op_t ALU_SUB = 3'd1;
    localparam alu_op_t ALU_AND = 3'd2;
    localparam alu_op_t ALU_OR  = 3'd3;
    localparam alu_op_t ALU_XOR = 3'd4;
    localparam alu_op_t ALU_LUI = 3'd5; // Passes operand B through
    localparam alu_op_t ALU_NOP = 3'd7;

    // Register-register forms, bits 31:15
    localparam logic [16:0] OP_ADD_W = 17'h00020;
    localparam logic [16:0] OP_SUB_W = 17'h00022;
    localparam logic [16:0] OP_AND   = 17'h00029;
    localparam logic [16:0] OP_OR    = 17'h0002a;
    localparam logic [16:0] OP_XOR   = 17'h0002b;

    // Immediate forms
    localparam logic [9:0]  OP_ADDI_W  = 10'h00a; // Bits 31:22
    localparam logic [6:0]  OP_LU12I_W = 7'h0a;   // Bits 31:25

endpackage

`default_nettype wire

/* verilog/instr_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_buffer import core_pkg::*; #(
    parameter int IB_DEPTH = 8
) (
    input  logic       clk,
    input  logic       rst_n_i,
    input  logic       instr_valid_i,
    input  instr_t     instr_i,
    input  logic [1:0] pop_count_i,
    output instr_t     head_instr_o [NUM_LANES],
    output logic [1:0] head_count_o,
    output logic [1:0] credit_return_o
);

    localparam int PTR_W = $clog2(IB_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    instr_t             mem [IB_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;

    // Two oldest entries, valid as far as head_count says
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            head_instr_o[l] = mem[rd_ptr + PTR_W'(l)];
        end
    end

    always_comb begin
        if (count >= CNT_W'(2)) begin
            head_count_o = 2'd2;
        end else begin
            head_count_o = count[1:0];
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            mem[wr_ptr] <= instr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wr_ptr          <= '0;
            rd_ptr          <= '0;
            count           <= '0;
            credit_return_o <= 2'd0;
        end else begin
            if (instr_valid_i) begin
                wr_ptr <= wr_ptr + 1'b1; // Wraps at power-of-two depth
            end
            rd_ptr          <= rd_ptr + PTR_W'(pop_count_i);
            count           <= count + CNT_W'(instr_valid_i) - CNT_W'(pop_count_i);
            credit_return_o <= pop_count_i; // Freed slots go back next cycle
        end
    end

endmodule

`default_nettype wire

/* verilog/decoder.sv */
`timescale 1ns/1ns
`default_nettype none

module decoder import core_pkg::*; (
    input  instr_t    instr_i,
    output alu_op_t   alu_op_o,
    output reg_addr_t rd_o,
    output reg_addr_t rj_o,
    output reg_addr_t rk_o,
    output logic      uses_rk_o,
    output word_t     imm_o,
    output logic      we_o
);

    // Register fields sit at fixed positions
    assign rd_o = instr_i[4:0];
    assign rj_o = instr_i[9:5];
    assign rk_o = instr_i[14:10];

    always_comb begin
        alu_op_o  = ALU_NOP;
        uses_rk_o = 1'b0;
        imm_o     = '0;
        if (instr_i[31:15] == OP_ADD_W) begin
            alu_op_o  = ALU_ADD;
            uses_rk_o = 1'b1;
        end else if (instr_i[31:15] == OP_SUB_W) begin
            alu_op_o  = ALU_SUB;
            uses_rk_o = 1'b1;
        end else if (instr_i[31:15] == OP_AND) begin
            alu_op_o  = ALU_AND;
            uses_rk_o = 1'b1;
        end else if (instr_i[31:15] == OP_OR) begin
            alu_op_o  = ALU_OR;
            uses_rk_o = 1'b1;
        end else if (instr_i[31:15] == OP_XOR) begin
            alu_op_o  = ALU_XOR;
            uses_rk_o = 1'b1;
        end else if (instr_i[31:22] == OP_ADDI_W) begin
            alu_op_o = ALU_ADD;
            imm_o    = {{20{instr_i[21]}}, instr_i[21:10]}; // si12
        end else if (instr_i[31:25] == OP_LU12I_W) begin
            alu_op_o = ALU_LUI;
            imm_o    = {instr_i[24:5], 12'b0}; // si20 in the upper bits
        end
    end

    // No write for unknown encodings or r0
    assign we_o = (alu_op_o != ALU_NOP) && (rd_o != '0);

endmodule

`default_nettype wire

/* verilog/dispatch.sv */
`timescale 1ns/1ns
`default_nettype none

module dispatch import core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [1:0]           head_count_i,
    input  alu_op_t              alu_op_i [NUM_LANES],
    input  reg_addr_t            rd_i [NUM_LANES],
    input  reg_addr_t            rj_i [NUM_LANES],
    input  reg_addr_t            rk_i [NUM_LANES],
    input  logic [NUM_LANES-1:0] uses_rk_i,
    input  word_t                imm_i [NUM_LANES],
    input  logic [NUM_LANES-1:0] we_i,
    output logic [1:0]           pop_count_o,
    output reg_addr_t            rf_raddr_o [2*NUM_LANES],
    input  word_t                rf_rdata_i [2*NUM_LANES],
    output logic [NUM_LANES-1:0] issue_valid_o,
    output alu_op_t              issue_op_o [NUM_LANES],
    output reg_addr_t            issue_rd_o [NUM_LANES],
    output logic [NUM_LANES-1:0] issue_we_o,
    output word_t                issue_a_o [NUM_LANES],
    output word_t                issue_b_o [NUM_LANES]
);

    logic [NUM_LANES-1:0] go;
    logic [NUM_LANES-1:0] src_busy;
    logic                 pair_dep;

    // Result still one stage away from the register file
    function automatic logic in_flight(input reg_addr_t r);
        logic hit;
        hit = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            if (issue_valid_o[l] && issue_we_o[l] && issue_rd_o[l] == r) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            src_busy[l] = in_flight(rj_i[l]) || (uses_rk_i[l] && in_flight(rk_i[l]));
        end
        // Younger lane reading what the older one writes
        pair_dep = we_i[0] &&
                   (rj_i[1] == rd_i[0] || (uses_rk_i[1] && rk_i[1] == rd_i[0]));
        go[0] = (head_count_i != 2'd0) && !src_busy[0];
        go[1] = go[0] && (head_count_i == 2'd2) && !pair_dep && !src_busy[1];
    end

    assign pop_count_o = go[1] ? 2'd2 : (go[0] ? 2'd1 : 2'd0);

    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            rf_raddr_o[2*l]   = rj_i[l];
            rf_raddr_o[2*l+1] = rk_i[l];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            issue_valid_o <= '0;
            issue_we_o    <= '0;
        end else begin
            issue_valid_o <= go;
            issue_we_o    <= go & we_i;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            issue_op_o[l] <= alu_op_i[l];
            issue_rd_o[l] <= rd_i[l];
            issue_a_o[l]  <= rf_rdata_i[2*l];
            issue_b_o[l]  <= uses_rk_i[l] ? rf_rdata_i[2*l+1] : imm_i[l];
        end
    end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module regfile import core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  reg_addr_t            raddr_i [2*NUM_LANES],
    output word_t                rdata_o [2*NUM_LANES],
    input  logic [NUM_LANES-1:0] we_i,
    input  reg_addr_t            waddr_i [NUM_LANES],
    input  word_t                wdata_i [NUM_LANES]
);

    word_t regs [32];

    // Later lane overwrites, so lane 1 wins a collision
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int r = 0; r < 32; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (we_i[l] && waddr_i[l] != '0) begin
                    regs[waddr_i[l]] <= wdata_i[l];
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 2*NUM_LANES; p++) begin
            rdata_o[p] = regs[raddr_i[p]];
            for (int l = 0; l < NUM_LANES; l++) begin
                if (we_i[l] && waddr_i[l] == raddr_i[p]) begin
                    rdata_o[p] = wdata_i[l]; // Write-through
                end
            end
            if (raddr_i[p] == '0) begin
                rdata_o[p] = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/exec_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_stage import core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic [NUM_LANES-1:0] issue_valid_i,
    input  alu_op_t              issue_op_i [NUM_LANES],
    input  reg_addr_t            issue_rd_i [NUM_LANES],
    input  logic [NUM_LANES-1:0] issue_we_i,
    input  word_t                issue_a_i [NUM_LANES],
    input  word_t                issue_b_i [NUM_LANES],
    output logic [NUM_LANES-1:0] commit_valid_o,
    output logic [NUM_LANES-1:0] commit_we_o,
    output reg_addr_t            commit_reg_o [NUM_LANES],
    output word_t                commit_data_o [NUM_LANES]
);

    word_t result [NUM_LANES];

    function automatic word_t alu(input alu_op_t op, input word_t a, input word_t b);
        word_t y;
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_XOR: y = a ^ b;
            ALU_LUI: y = b;     // Immediate already shifted
            default: y = '0;
        endcase
        return y;
    endfunction

    // One ALU per lane
    always_comb begin
        for (int l = 0; l < NUM_LANES; l++) begin
            result[l] = alu(issue_op_i[l], issue_a_i[l], issue_b_i[l]);
        end
    end

    // Writeback register
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            commit_valid_o <= '0;
            commit_we_o    <= '0;
        end else begin
            commit_valid_o <= issue_valid_i;
            commit_we_o    <= issue_valid_i & issue_we_i;
        end
    end

    always_ff @(posedge clk) begin
        for (int l = 0; l < NUM_LANES; l++) begin
            commit_reg_o[l]  <= issue_rd_i[l];
            commit_data_o[l] <= result[l];
        end
    end

endmodule

`default_nettype wire

/* verilog/dual_issue_core.sv */
`timescale 1ns/1ns
`default_nettype none

module dual_issue_core import core_pkg::*; #(
    parameter int IB_DEPTH = 8
) (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 instr_valid_i,
    input  instr_t               instr_i,
    output logic [1:0]           credit_return_o,
    output logic [NUM_LANES-1:0] commit_valid_o,
    output logic [NUM_LANES-1:0] commit_we_o,
    output reg_addr_t            commit_reg_o [NUM_LANES],
    output word_t                commit_data_o [NUM_LANES]
);

    instr_t               head_instr [NUM_LANES];
    logic [1:0]           head_count;
    logic [1:0]           pop_count;

    alu_op_t              dec_op [NUM_LANES];
    reg_addr_t            dec_rd [NUM_LANES];
    reg_addr_t            dec_rj [NUM_LANES];
    reg_addr_t            dec_rk [NUM_LANES];
    word_t                dec_imm [NUM_LANES];
    logic [NUM_LANES-1:0] dec_uses_rk;
    logic [NUM_LANES-1:0] dec_we;

    reg_addr_t            rf_raddr [2*NUM_LANES];
    word_t                rf_rdata [2*NUM_LANES];

    logic [NUM_LANES-1:0] issue_valid;
    logic [NUM_LANES-1:0] issue_we;
    alu_op_t              issue_op [NUM_LANES];
    reg_addr_t            issue_rd [NUM_LANES];
    word_t                issue_a [NUM_LANES];
    word_t                issue_b [NUM_LANES];

    instr_buffer #(.IB_DEPTH(IB_DEPTH)) u_instr_buffer (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .instr_valid_i  (instr_valid_i),
        .instr_i        (instr_i),
        .pop_count_i    (pop_count),
        .head_instr_o   (head_instr),
        .head_count_o   (head_count),
        .credit_return_o(credit_return_o)
    );

    // Lane 0 decodes the older instruction
    for (genvar l = 0; l < NUM_LANES; l++) begin : g_dec
        decoder u_decoder (
            .instr_i   (head_instr[l]),
            .alu_op_o  (dec_op[l]),
            .rd_o      (dec_rd[l]),
            .rj_o      (dec_rj[l]),
            .rk_o      (dec_rk[l]),
            .uses_rk_o (dec_uses_rk[l]),
            .imm_o     (dec_imm[l]),
            .we_o      (dec_we[l])
        );
    end

    dispatch u_dispatch (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .head_count_i (head_count),
        .alu_op_i     (dec_op),
        .rd_i         (dec_rd),
        .rj_i         (dec_rj),
        .rk_i         (dec_rk),
        .uses_rk_i    (dec_uses_rk),
        .imm_i        (dec_imm),
        .we_i         (dec_we),
        .pop_count_o  (pop_count),
        .rf_raddr_o   (rf_raddr),
        .rf_rdata_i   (rf_rdata),
        .issue_valid_o(issue_valid),
        .issue_op_o   (issue_op),
        .issue_rd_o   (issue_rd),
        .issue_we_o   (issue_we),
        .issue_a_o    (issue_a),
        .issue_b_o    (issue_b)
    );

    // Writeback register feeds the write ports
    regfile u_regfile (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .raddr_i(rf_raddr),
        .rdata_o(rf_rdata),
        .we_i   (commit_we_o),
        .waddr_i(commit_reg_o),
        .wdata_i(commit_data_o)
    );

    exec_stage u_exec_stage (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid),
        .issue_op_i    (issue_op),
        .issue_rd_i    (issue_rd),
        .issue_we_i    (issue_we),
        .issue_a_i     (issue_a),
        .issue_b_i     (issue_b),
        .commit_valid_o(commit_valid_o),
        .commit_we_o   (commit_we_o),
        .commit_reg_o  (commit_reg_o),
        .commit_data_o (commit_data_o)
    );

endmodule

`default_nettype wire

/* test/commit_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module commit_checker import core_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n_i,
    input  logic                 instr_valid_i,
    input  instr_t               instr_i,
    input  logic [NUM_LANES-1:0] commit_valid_i,
    input  logic [NUM_LANES-1:0] commit_we_i,
    input  reg_addr_t            commit_reg_i [NUM_LANES],
    input  word_t                commit_data_i [NUM_LANES],
    output int                   error_count_o,
    output int                   commit_count_o,
    output int                   pending_o
);

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     val;
    } wr_t;

    word_t  ref_regs [32] = '{default: '0};
    wr_t    model_q [$];
    wr_t    table_q [$];
    logic   chk_q [$];
    string  name_q [$];

    string  tag_name = "";
    logic   tag_chk = 1'b0;
    wr_t    tag_exp = '0;
    logic   cap_valid = 1'b0;
    instr_t cap_instr;
    string  cap_name;
    logic   cap_chk;
    wr_t    cap_exp;

    // Label for the next instruction the sender drives
    task automatic set_tag(input string name, input logic chk, input logic we,
                           input reg_addr_t rd, input word_t val);
        tag_name = name;
        tag_chk  = chk;
        tag_exp  = {we, rd, val};
    endtask

    // Reference model, updated in program order
    task automatic accept(input instr_t ins, input string name, input logic chk,
                          input wr_t tab);
        wr_t   exp;
        word_t a;
        word_t b;
        a       = ref_regs[ins[9:5]];
        b       = ref_regs[ins[14:10]];
        exp.we  = 1'b1;
        exp.rd  = ins[4:0];
        exp.val = '0;
        if (ins[31:15] == OP_ADD_W) exp.val = a + b;
        else if (ins[31:15] == OP_SUB_W) exp.val = a - b;
        else if (ins[31:15] == OP_AND) exp.val = a & b;
        else if (ins[31:15] == OP_OR) exp.val = a | b;
        else if (ins[31:15] == OP_XOR) exp.val = a ^ b;
        else if (ins[31:22] == OP_ADDI_W) exp.val = a + {{20{ins[21]}}, ins[21:10]};
        else if (ins[31:25] == OP_LU12I_W) exp.val = {ins[24:5], 12'h000};
        else exp.we = 1'b0; // Unknown encoding
        if (exp.rd == '0) exp.we = 1'b0;
        if (exp.we) ref_regs[exp.rd] = exp.val;
        model_q.push_back(exp);
        table_q.push_back(tab);
        chk_q.push_back(chk);
        name_q.push_back(name);
    endtask

    task automatic compare(input string name, input string what, input wr_t exp,
                           input logic we, input reg_addr_t rd, input word_t data);
        if (we !== exp.we) begin
            error_count_o++;
            $display("Error %s (%s): expected we %0b, actual we %0b", name, what, exp.we, we);
        end else if (exp.we && (rd !== exp.rd || data !== exp.val)) begin
            error_count_o++;
            $display("Error %s (%s): expected r%0d = %h, actual r%0d = %h",
                     name, what, exp.rd, exp.val, rd, data);
        end
    endtask

    task automatic retire(input int l);
        if (name_q.size() == 0) begin
            error_count_o++;
            $display("Lane %0d committed with no instruction outstanding", l);
            return;
        end
        compare(name_q[0], "model", model_q[0], commit_we_i[l], commit_reg_i[l],
                commit_data_i[l]);
        if (chk_q[0]) begin
            compare(name_q[0], "table", table_q[0], commit_we_i[l], commit_reg_i[l],
                    commit_data_i[l]);
        end
        void'(model_q.pop_front());
        void'(table_q.pop_front());
        void'(chk_q.pop_front());
        void'(name_q.pop_front());
        commit_count_o++;
    endtask

    // Accepted at the rising edge
    always @(posedge clk) begin
        cap_valid <= rst_n_i && instr_valid_i;
        cap_instr <= instr_i;
        cap_name  <= tag_name;
        cap_chk   <= tag_chk;
        cap_exp   <= tag_exp;
    end

    always @(negedge clk) begin
        if (cap_valid) begin
            accept(cap_instr, cap_name, cap_chk, cap_exp);
        end
        if (rst_n_i) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (commit_valid_i[l]) begin
                    retire(l); // Lane 0 first, it is older
                end
            end
        end
        pending_o = name_q.size();
    end

endmodule

`default_nettype wire

/* test/tb_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_core import core_pkg::*; ();

    localparam int IB_DEPTH   = 8;
    localparam int NUM_ROWS   = 16;
    localparam int NUM_RANDOM = 200;
    localparam int TIMEOUT    = 500; // Cycles per wait

    logic                 clk;
    logic                 rst_n;
    logic                 instr_valid;
    instr_t               instr;
    logic [1:0]           credit_return;
    logic [NUM_LANES-1:0] commit_valid;
    logic [NUM_LANES-1:0] commit_we;
    reg_addr_t            commit_reg [NUM_LANES];
    word_t                commit_data [NUM_LANES];

    int sent;
    int returned;
    int credit_errors;
    int timeout_errors;
    int count_errors;
    int chk_errors;
    int chk_commits;
    int chk_pending;

    string     row_name [NUM_ROWS];
    instr_t    row_instr [NUM_ROWS];
    logic      row_we [NUM_ROWS];
    reg_addr_t row_rd [NUM_ROWS];
    word_t     row_val [NUM_ROWS];

    dual_issue_core #(.IB_DEPTH(IB_DEPTH)) dut (
        .clk            (clk),
        .rst_n_i        (rst_n),
        .instr_valid_i  (instr_valid),
        .instr_i        (instr),
        .credit_return_o(credit_return),
        .commit_valid_o (commit_valid),
        .commit_we_o    (commit_we),
        .commit_reg_o   (commit_reg),
        .commit_data_o  (commit_data)
    );

    commit_checker u_checker (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .commit_valid_i(commit_valid),
        .commit_we_i   (commit_we),
        .commit_reg_i  (commit_reg),
        .commit_data_i (commit_data),
        .error_count_o (chk_errors),
        .commit_count_o(chk_commits),
        .pending_o     (chk_pending)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic instr_t rr_instr(input logic [16:0] op, input reg_addr_t rd,
                                        input reg_addr_t rj, input reg_addr_t rk);
        return {op, rk, rj, rd};
    endfunction

    function automatic instr_t addi_instr(input reg_addr_t rd, input reg_addr_t rj,
                                          input logic [11:0] imm);
        return {OP_ADDI_W, imm, rj, rd};
    endfunction

    function automatic instr_t lu12i_instr(input reg_addr_t rd, input logic [19:0] imm);
        return {OP_LU12I_W, imm, rd};
    endfunction

    task automatic set_row(input int i, input string n, input instr_t w, input logic we,
                           input reg_addr_t rd, input word_t v);
        row_name[i]  = n;
        row_instr[i] = w;
        row_we[i]    = we;
        row_rd[i]    = rd;
        row_val[i]   = v;
    endtask

    // Falling edge, where returned credits are counted
    task automatic tick();
        @(negedge clk);
        if (rst_n) begin
            returned += int'(credit_return);
            if (returned > sent || sent - returned > IB_DEPTH) begin
                credit_errors++;
                $display("Credit count out of range: %0d sent, %0d returned", sent, returned);
            end
        end
    endtask

    task automatic send(input string name, input instr_t w, input logic chk, input logic we,
                        input reg_addr_t rd, input word_t v);
        int waited;
        waited = 0;
        while (sent - returned >= IB_DEPTH && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (sent - returned >= IB_DEPTH) begin
            timeout_errors++;
            $display("Timed out waiting for a credit to send %s", name);
            return;
        end
        u_checker.set_tag(name, chk, we, rd, v);
        instr_valid = 1'b1;
        instr       = w;
        sent++;
        tick();
        instr_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while ((chk_pending != 0 || returned != sent) && waited < TIMEOUT) begin
            tick();
            waited++;
        end
        if (chk_pending != 0 || returned != sent) begin
            timeout_errors++;
            $display("Timed out waiting for the core to drain, %0d still pending", chk_pending);
        end
        repeat (4) tick();
    endtask

    initial begin
        int        kind;
        instr_t    w;
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        void'($urandom(32'h13eb_adab));
        rst_n          = 1'b0;
        instr_valid    = 1'b0;
        instr          = '0;
        sent           = 0;
        returned       = 0;
        credit_errors  = 0;
        timeout_errors = 0;
        count_errors   = 0;

        // Expected values worked out by hand
        set_row(0, "lu12i", lu12i_instr(5'd1, 20'h12345), 1'b1, 5'd1, 32'h1234_5000);
        set_row(1, "addi_pos", addi_instr(5'd2, 5'd0, 12'h7ff), 1'b1, 5'd2, 32'h0000_07ff);
        set_row(2, "addi_neg", addi_instr(5'd3, 5'd0, 12'hfff), 1'b1, 5'd3, 32'hffff_ffff);
        set_row(3, "add", rr_instr(OP_ADD_W, 5'd4, 5'd1, 5'd2), 1'b1, 5'd4, 32'h1234_57ff);
        set_row(4, "sub", rr_instr(OP_SUB_W, 5'd5, 5'd2, 5'd3), 1'b1, 5'd5, 32'h0000_0800);
        set_row(5, "and", rr_instr(OP_AND, 5'd6, 5'd4, 5'd2), 1'b1, 5'd6, 32'h0000_07ff);
        set_row(6, "or", rr_instr(OP_OR, 5'd7, 5'd1, 5'd2), 1'b1, 5'd7, 32'h1234_57ff);
        set_row(7, "xor", rr_instr(OP_XOR, 5'd8, 5'd4, 5'd3), 1'b1, 5'd8, 32'hedcb_a800);
        set_row(8, "raw_back", addi_instr(5'd9, 5'd8, 12'h001), 1'b1, 5'd9, 32'hedcb_a801);
        set_row(9, "raw_pair", rr_instr(OP_ADD_W, 5'd10, 5'd9, 5'd9), 1'b1, 5'd10, 32'hdb97_5002);
        // Stalls on r10 and then pairs with waw_second
        set_row(10, "waw_first", addi_instr(5'd11, 5'd10, 12'h005), 1'b1, 5'd11, 32'hdb97_5007);
        set_row(11, "waw_second", addi_instr(5'd11, 5'd0, 12'h006), 1'b1, 5'd11, 32'd6);
        set_row(12, "waw_read", rr_instr(OP_ADD_W, 5'd12, 5'd11, 5'd0), 1'b1, 5'd12, 32'd6);
        set_row(13, "dest_r0", addi_instr(5'd0, 5'd1, 12'h001), 1'b0, 5'd0, 32'd0);
        set_row(14, "unknown", 32'hffff_ffff, 1'b0, 5'd0, 32'd0);
        set_row(15, "r0_read", rr_instr(OP_OR, 5'd13, 5'd0, 5'd1), 1'b1, 5'd13, 32'h1234_5000);

        repeat (10) tick();
        rst_n = 1'b1;

        for (int i = 0; i < NUM_ROWS; i++) begin
            send(row_name[i], row_instr[i], 1'b1, row_we[i], row_rd[i], row_val[i]);
        end

        // Few registers, so hazards come often
        for (int n = 0; n < NUM_RANDOM; n++) begin
            kind = int'($urandom_range(0, 6));
            rd   = 5'($urandom_range(0, 7));
            rj   = 5'($urandom_range(0, 7));
            rk   = 5'($urandom_range(0, 7));
            case (kind)
                0: w = rr_instr(OP_ADD_W, rd, rj, rk);
                1: w = rr_instr(OP_SUB_W, rd, rj, rk);
                2: w = rr_instr(OP_AND, rd, rj, rk);
                3: w = rr_instr(OP_OR, rd, rj, rk);
                4: w = rr_instr(OP_XOR, rd, rj, rk);
                5: w = addi_instr(rd, rj, 12'($urandom));
                default: w = lu12i_instr(rd, 20'($urandom));
            endcase
            send("random", w, 1'b0, 1'b0, '0, '0);
            if ($urandom_range(0, 3) == 0) begin
                repeat ($urandom_range(1, 3)) tick(); // Idle gap
            end
        end

        drain();
        if (chk_commits != sent) begin
            count_errors++;
            $display("Commit count %0d differs from %0d instructions sent", chk_commits, sent);
        end
        if (returned != sent) begin
            count_errors++;
            $display("Credits returned %0d differ from %0d instructions sent", returned, sent);
        end
        $display("Errors: %0d checker, %0d credit, %0d count, %0d timeout",
                 chk_errors, credit_errors, count_errors, timeout_errors);
        if (chk_errors + credit_errors + count_errors + timeout_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
verilog/core_pkg.sv
verilog/instr_buffer.sv
verilog/decoder.sv
verilog/dispatch.sv
verilog/regfile.sv
verilog/exec_stage.sv
verilog/dual_issue_core.sv
test/commit_checker.sv
test/tb_core.sv

/* run.sh */
#!/bin/sh
# Build and run the dual-issue core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_core \
    -f flist.f --Mdir obj_dir -o tb_core

./obj_dir/tb_core | tee sim.log

if grep -qx '>>> PASS' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi
